// File: hdl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int addr_w = 11;
    localparam int data_w = 8;
    localparam logic [3:0] device_code = 4'b1010;  // 24Cxx family

    // bit timing, SCL high in the two upper phases
    localparam int phases_per_bit = 4;
    localparam logic [1:0] last_phase = 2'(phases_per_bit - 1);
    localparam logic [3:0] ack_bit = 4'd8;  // ninth bit of a byte symbol

    typedef enum logic [1:0] {
        sym_start = 2'd0,
        sym_stop  = 2'd1,
        sym_send  = 2'd2,
        sym_recv  = 2'd3
    } sym_cmd_t;

    // one-hot transaction states
    typedef enum logic [9:0] {
        idle     = 10'b00_0000_0001,
        wr_start = 10'b00_0000_0010,
        wr_ctrl  = 10'b00_0000_0100,
        wr_addr  = 10'b00_0000_1000,
        wr_data  = 10'b00_0001_0000,
        rd_start = 10'b00_0010_0000,
        rd_ctrl  = 10'b00_0100_0000,
        rd_data  = 10'b00_1000_0000,
        stop     = 10'b01_0000_0000,
        done     = 10'b10_0000_0000
    } seq_state_t;

    typedef struct packed {
        logic [3:0] device;
        logic [2:0] block;  // A10..A8
        logic       rw;     // 1 = read
    } ctrl_fields_t;

    // control byte, built by fields and shifted out as a byte
    typedef union packed {
        logic [data_w-1:0] raw;
        ctrl_fields_t      f;
    } ctrl_byte_u;

endpackage

// File: hdl/i2c_cmd_if.sv
`timescale 1ns/1ps

interface i2c_cmd_if;

    // requests from the sequencer
    eeprom_pkg::sym_cmd_t cmd;
    logic go;  // one cycle, engine idle
    logic [eeprom_pkg::data_w-1:0] tx_byte;
    logic master_ack;  // level for the ack slot of a receive

    // results from the bit engine, held until the next go
    logic [eeprom_pkg::data_w-1:0] rx_byte;
    logic slave_nack;
    logic sym_done;  // last cycle of the symbol

    modport seq (
        output cmd,
        output go,
        output tx_byte,
        output master_ack,
        input  rx_byte,
        input  slave_nack,
        input  sym_done
    );

    modport engine (
        input  cmd,
        input  go,
        input  tx_byte,
        input  master_ack,
        output rx_byte,
        output slave_nack,
        output sym_done
    );

endinterface

// File: hdl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic CLK,
    input  logic RESET,
    input  logic sda_in,
    output logic scl,
    output logic sda_low,
    i2c_cmd_if.engine bus
);

    logic active;  // symbol in progress
    eeprom_pkg::sym_cmd_t cur;
    logic [1:0] phase;
    logic [3:0] bit_cnt;
    logic [eeprom_pkg::data_w-1:0] shreg;
    logic nack_q;
    logic short_sym;
    logic last;
    logic in_ack;

    // START and STOP are a single bit time
    assign short_sym = (cur == eeprom_pkg::sym_start) || (cur == eeprom_pkg::sym_stop);
    assign in_ack = (bit_cnt == eeprom_pkg::ack_bit);
    assign last = active && (phase == eeprom_pkg::last_phase) && (short_sym || in_ack);

    assign bus.sym_done = last;
    assign bus.rx_byte = shreg;
    assign bus.slave_nack = nack_q;

    // sequencing, SCL and SDA
    always_ff @(posedge CLK) begin
        if (RESET) begin
            active <= 1'b0;
            cur <= eeprom_pkg::sym_stop;
            phase <= '0;
            bit_cnt <= '0;
            nack_q <= 1'b0;
            scl <= 1'b1;  // bus idle
            sda_low <= 1'b0;
        end else if (!active) begin
            if (bus.go) begin
                active <= 1'b1;
                cur <= bus.cmd;
                phase <= '0;
                bit_cnt <= '0;
                nack_q <= 1'b0;
                scl <= 1'b0;  // phase 0 of the first bit
            end
        end else begin
            phase <= phase + 2'd1;
            // high in phases 2 and 3, stays high after the last bit
            scl <= (phase == 2'd1) || (phase == 2'd2) || last;
            if (phase == eeprom_pkg::last_phase) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            if (last) begin
                active <= 1'b0;
            end

            case (cur)
                eeprom_pkg::sym_start: begin
                    if (phase == 2'd0) begin
                        sda_low <= 1'b0;  // release first, allows repeated start
                    end
                    if (phase == 2'd2) begin
                        sda_low <= 1'b1;  // falls while SCL high
                    end
                end
                eeprom_pkg::sym_stop: begin
                    if (phase == 2'd0) begin
                        sda_low <= 1'b1;
                    end
                    if (phase == 2'd2) begin
                        sda_low <= 1'b0;  // rises while SCL high
                    end
                end
                eeprom_pkg::sym_send: begin
                    if (phase == 2'd0) begin
                        sda_low <= in_ack ? 1'b0 : !shreg[eeprom_pkg::data_w-1];
                    end
                    if (in_ack && phase == 2'd2) begin
                        nack_q <= sda_in;  // slave should pull low
                    end
                end
                default: begin
                    // receive, master drives only the ack slot
                    if (phase == 2'd0) begin
                        sda_low <= in_ack ? !bus.master_ack : 1'b0;
                    end
                end
            endcase
        end
    end

    // shared shift register, msb first in both directions
    always_ff @(posedge CLK) begin
        if (!active && bus.go) begin
            shreg <= bus.tx_byte;
        end else if (active && !in_ack) begin
            if (cur == eeprom_pkg::sym_send && phase == 2'd0) begin
                shreg <= {shreg[eeprom_pkg::data_w-2:0], 1'b0};
            end else if (cur == eeprom_pkg::sym_recv && phase == 2'd2) begin
                shreg <= {shreg[eeprom_pkg::data_w-2:0], sda_in};
            end
        end
    end

endmodule

// File: hdl/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic CLK,
    input  logic RESET,
    input  logic wr,
    input  logic rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    input  logic [eeprom_pkg::data_w-1:0] wdata,
    output logic [eeprom_pkg::data_w-1:0] rdata,
    output logic ack,
    output logic nack,
    output logic busy,
    i2c_cmd_if.seq bus
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t nxt;
    eeprom_pkg::sym_cmd_t nxt_cmd;
    eeprom_pkg::ctrl_byte_u ctrl;
    logic [eeprom_pkg::data_w-1:0] nxt_byte;
    logic [eeprom_pkg::addr_w-1:0] addr_q;
    logic [eeprom_pkg::data_w-1:0] wdata_q;
    logic is_read;
    logic accept;

    // strobes only count in idle or in the ack cycle, write wins
    assign accept = ((state == eeprom_pkg::idle) || (state == eeprom_pkg::done)) && (wr || rd);

    assign busy = !((state == eeprom_pkg::idle) || (state == eeprom_pkg::done));
    assign ack = (state == eeprom_pkg::done);
    assign bus.master_ack = (state == eeprom_pkg::rd_data);  // NACK the single read byte

    always_comb begin
        nxt = state;
        case (state)
            eeprom_pkg::idle: begin
                if (accept) begin
                    nxt = eeprom_pkg::wr_start;
                end
            end
            eeprom_pkg::done: begin
                nxt = accept ? eeprom_pkg::wr_start : eeprom_pkg::idle;
            end
            eeprom_pkg::wr_start: begin
                if (bus.sym_done) begin
                    nxt = eeprom_pkg::wr_ctrl;
                end
            end
            eeprom_pkg::wr_ctrl: begin
                if (bus.sym_done) begin
                    nxt = bus.slave_nack ? eeprom_pkg::stop : eeprom_pkg::wr_addr;
                end
            end
            eeprom_pkg::wr_addr: begin
                if (bus.sym_done) begin
                    if (bus.slave_nack) begin
                        nxt = eeprom_pkg::stop;
                    end else begin
                        nxt = is_read ? eeprom_pkg::rd_start : eeprom_pkg::wr_data;
                    end
                end
            end
            eeprom_pkg::rd_start: begin
                if (bus.sym_done) begin
                    nxt = eeprom_pkg::rd_ctrl;
                end
            end
            eeprom_pkg::rd_ctrl: begin
                if (bus.sym_done) begin
                    nxt = bus.slave_nack ? eeprom_pkg::stop : eeprom_pkg::rd_data;
                end
            end
            eeprom_pkg::wr_data, eeprom_pkg::rd_data: begin
                if (bus.sym_done) begin
                    nxt = eeprom_pkg::stop;
                end
            end
            eeprom_pkg::stop: begin
                if (bus.sym_done) begin
                    nxt = eeprom_pkg::done;
                end
            end
            default: nxt = eeprom_pkg::idle;
        endcase
    end

    // symbol for the state being entered
    always_comb begin
        ctrl.f.device = eeprom_pkg::device_code;
        ctrl.f.block = addr_q[eeprom_pkg::addr_w-1:eeprom_pkg::data_w];
        ctrl.f.rw = (nxt == eeprom_pkg::rd_ctrl);
        nxt_cmd = eeprom_pkg::sym_send;
        nxt_byte = ctrl.raw;
        case (nxt)
            eeprom_pkg::wr_start, eeprom_pkg::rd_start: nxt_cmd = eeprom_pkg::sym_start;
            eeprom_pkg::stop: nxt_cmd = eeprom_pkg::sym_stop;
            eeprom_pkg::rd_data: nxt_cmd = eeprom_pkg::sym_recv;
            eeprom_pkg::wr_addr: nxt_byte = addr_q[eeprom_pkg::data_w-1:0];
            eeprom_pkg::wr_data: nxt_byte = wdata_q;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= eeprom_pkg::idle;
            bus.go <= 1'b0;
            nack <= 1'b0;
            is_read <= 1'b0;
        end else begin
            state <= nxt;
            // one go per symbol state, none for done or idle
            bus.go <= (nxt != state) && (nxt != eeprom_pkg::done) && (nxt != eeprom_pkg::idle);
            if (accept) begin
                nack <= 1'b0;
                is_read <= !wr;
            end else if (bus.sym_done && bus.slave_nack) begin
                nack <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            addr_q <= addr;
            wdata_q <= wdata;
        end
        if (nxt != state) begin
            bus.cmd <= nxt_cmd;
            bus.tx_byte <= nxt_byte;
        end
        if (state == eeprom_pkg::rd_data && bus.sym_done) begin
            rdata <= bus.rx_byte;
        end
    end

endmodule

// File: hdl/eeprom_wr.sv
`timescale 1ns/1ps

module eeprom_wr (
    input  logic CLK,
    input  logic RESET,
    input  logic wr,
    input  logic rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    input  logic [eeprom_pkg::data_w-1:0] wdata,
    output logic [eeprom_pkg::data_w-1:0] rdata,
    output logic ack,
    output logic nack,
    output logic busy,
    output logic scl,
    output logic sda_low,  // open drain, 1 pulls SDA low
    input  logic sda_in
);

    i2c_cmd_if cmd_bus ();

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .busy  (busy),
        .bus   (cmd_bus.seq)
    );

    i2c_bit_engine u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low),
        .bus     (cmd_bus.engine)
    );

endmodule

// File: tests/eeprom_model.sv
`timescale 1ns/1ps

// behavioral 24C16, byte write and random read only
module eeprom_model (
    input  logic scl,
    input  logic sda,      // resolved bus level
    input  logic respond,  // 0 = slave absent, no acks
    output logic low       // 1 pulls SDA low
);

    logic [7:0] mem [0:2047];
    logic prev_scl;
    logic prev_sda;
    logic started;
    logic sel;
    logic reading;
    logic rw;
    logic [2:0] blk;
    logic [7:0] ptr;
    logic [7:0] sh;
    logic [7:0] tx;
    int bit_idx;
    int byte_idx;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hff;  // erased part
        end
        low = 1'b0;
        started = 1'b0;
        sel = 1'b0;
        reading = 1'b0;
        rw = 1'b0;
        blk = '0;
        ptr = '0;
        sh = '0;
        tx = '0;
        bit_idx = 0;
        byte_idx = 0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
    end

    always @(scl or sda) begin
        if (scl && prev_scl && (sda != prev_sda)) begin
            if (!sda) begin  // START or repeated START
                started = 1'b1;
                sel = 1'b0;
                reading = 1'b0;
                bit_idx = 0;
                byte_idx = 0;
                sh = '0;
            end else begin  // STOP
                started = 1'b0;
                reading = 1'b0;
            end
            low = 1'b0;
        end else if (scl && !prev_scl && started) begin
            if (!reading && bit_idx < 8) begin
                sh = {sh[6:0], sda};
            end
            bit_idx++;
        end else if (!scl && prev_scl && started) begin
            if (reading) begin
                if (bit_idx >= 1 && bit_idx <= 7) begin
                    low = !tx[7-bit_idx];
                end else if (bit_idx == 8) begin
                    low = 1'b0;  // master ack slot
                end else if (bit_idx >= 9) begin
                    low = 1'b0;
                    reading = 1'b0;
                    started = 1'b0;  // single byte read
                end
            end else if (bit_idx == 8) begin
                if (byte_idx == 0) begin
                    sel = respond && (sh[7:4] == 4'b1010);
                    blk = sh[3:1];
                    rw = sh[0];
                end else if (sel && byte_idx == 1) begin
                    ptr = sh;
                end else if (sel) begin
                    mem[{blk, ptr}] = sh;
                end
                low = sel;
            end else if (bit_idx >= 9) begin
                low = 1'b0;
                bit_idx = 0;
                if (!sel) begin
                    started = 1'b0;
                end else if (byte_idx == 0 && rw) begin
                    reading = 1'b1;
                    tx = mem[{blk, ptr}];
                    low = !tx[7];  // msb first
                end
                byte_idx++;
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

// File: tests/eeprom_wr_assert.sv
`timescale 1ns/1ps

module eeprom_wr_assert (
    input logic CLK,
    input logic RESET,
    input logic ack,
    input logic strobe,
    input logic busy,
    input logic scl,
    input logic sda_low,
    input logic start_stop  // START or STOP symbol, edges allowed with scl high
);

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack longer than one cycle");

    // idle and the ack cycle both take a strobe
    strobe_sets_busy: assert property (@(posedge CLK) disable iff (RESET)
        (strobe && !busy) |=> busy)
        else $error("busy did not rise after an accepted strobe");

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_low) && !start_stop) |-> !scl)
        else $error("sda_low changed while scl high");

endmodule

bind eeprom_sequencer eeprom_wr_assert seq_chk (
    .CLK        (CLK),
    .RESET      (RESET),
    .ack        (ack),
    .strobe     (wr | rd),
    .busy       (busy),
    .scl        (1'b0),
    .sda_low    (1'b0),
    .start_stop (1'b0)
);

bind i2c_bit_engine eeprom_wr_assert engine_chk (
    .CLK        (CLK),
    .RESET      (RESET),
    .ack        (1'b0),
    .strobe     (1'b0),
    .busy       (1'b0),
    .scl        (scl),
    .sda_low    (sda_low),
    .start_stop (short_sym)
);

// File: tests/tb_eeprom_wr.sv
`timescale 1ns/1ps

module tb_eeprom_wr;

    localparam int txn_bound = 200;  // cycles per transaction
    localparam int n_trans = 52;

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic [10:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic ack;
    logic nack;
    logic busy;
    logic scl;
    logic sda_low;
    logic sda_in;
    logic model_low;
    logic respond;

    logic [7:0] ref_mem [0:2047];
    logic written [0:2047];
    int errors;
    integer seed;

    assign sda_in = !(sda_low | model_low);  // open drain wired and

    eeprom_wr DUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .ack     (ack),
        .nack    (nack),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

    eeprom_model u_model (
        .scl     (scl),
        .sda     (sda_in),
        .respond (respond),
        .low     (model_low)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = !CLK;
    end

    initial begin
        repeat (n_trans * txn_bound + 100) @(posedge CLK);
        $display("Watchdog expired, tests did not finish");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic pulse(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr = is_wr;
        rd = !is_wr;
        addr = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack(output logic got);
        int n;
        n = 0;
        got = 1'b0;
        while (!got && n < txn_bound) begin
            if (ack) begin
                got = 1'b1;
            end else begin
                @(negedge CLK);
                n++;
            end
        end
        if (!got) begin
            $display("Timeout at %0t: no ack within %0d cycles", $time, txn_bound);
            errors++;
        end
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d, input logic exp_nack);
        logic got;
        pulse(1'b1, a, d);
        wait_ack(got);
        if (got && nack !== exp_nack) begin
            $display("Error at %0t: write %h nack %b expected %b", $time, a, nack, exp_nack);
            errors++;
        end
        if (!exp_nack) begin
            ref_mem[a] = d;
            written[a] = 1'b1;
        end
    endtask

    task automatic read_check(input logic [10:0] a);
        logic got;
        pulse(1'b0, a, 8'h00);
        wait_ack(got);
        if (got && nack !== 1'b0) begin
            $display("Error at %0t: read %h got nack", $time, a);
            errors++;
        end
        if (got && rdata !== ref_mem[a]) begin
            $display("Error at %0t: read %h got %h expected %h", $time, a, rdata, ref_mem[a]);
            errors++;
        end
    endtask

    task automatic write_then_read();
        write_byte(11'h123, 8'h5a, 1'b0);
        read_check(11'h123);
    endtask

    // same word address, different block bits
    task automatic block_bit_select();
        write_byte(11'h0ff, 8'haa, 1'b0);
        write_byte(11'h1ff, 8'h55, 1'b0);
        read_check(11'h0ff);
        read_check(11'h1ff);
    endtask

    task automatic random_traffic();
        logic [10:0] a;
        logic [7:0] d;
        for (int i = 0; i < 20; i++) begin
            a = 11'($random(seed));
            d = 8'($random(seed));
            write_byte(a, d, 1'b0);
            read_check(a);
        end
        a = 11'h7ff;
        while (written[a]) begin
            a = a - 11'd1;
        end
        read_check(a);  // never written, erased value
    endtask

    task automatic missing_slave();
        respond = 1'b0;
        write_byte(11'h2a5, 8'h3c, 1'b1);
        respond = 1'b1;
        read_check(11'h2a5);
    endtask

    task automatic dropped_strobe();
        logic got;
        int extra;
        pulse(1'b1, 11'h456, 8'hc3);
        repeat (3) @(negedge CLK);
        if (!busy) begin
            $display("Error at %0t: busy low during write", $time);
            errors++;
        end
        pulse(1'b1, 11'h456, 8'h3c);  // dropped
        wait_ack(got);
        ref_mem[11'h456] = 8'hc3;
        written[11'h456] = 1'b1;
        extra = 0;
        repeat (150) begin
            @(negedge CLK);
            if (ack) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("Error at %0t: %0d extra ack pulses", $time, extra);
            errors++;
        end
        read_check(11'h456);
    endtask

    initial begin
        seed = 32'h321cf0ec;
        errors = 0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        respond = 1'b1;
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = 8'hff;
            written[i] = 1'b0;
        end
        repeat (8) @(negedge CLK);
        RESET = 1'b0;
        repeat (2) @(negedge CLK);

        write_then_read();
        block_bit_select();
        random_traffic();
        missing_slave();
        dropped_strobe();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/eeprom_pkg.sv
hdl/i2c_cmd_if.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_wr.sv
tests/eeprom_model.sv
tests/eeprom_wr_assert.sv
tests/tb_eeprom_wr.sv

// File: Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_eeprom_wr
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
